//--- hdl/axi_pkg.sv
`default_nettype none

package axi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int LEN_W  = 4;
  localparam int SIZE_W = 3;

  // Codes 2 and 3 are unused (no WRAP)
  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1
  } burst_e;

  //////////////////////////////////////////////////////////////////////
  // Command and channel payloads
  //////////////////////////////////////////////////////////////////////

  // Command from the outside controller
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [SIZE_W-1:0] size;
    burst_e            burst;
    logic              write;
    logic [DATA_W-1:0] data_base;
  } burst_cmd_t;

  // Shared by AW and AR
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [SIZE_W-1:0] size;
    burst_e            burst;
  } addr_phase_t;

  // One received read beat with its address
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              last;
  } rd_beat_t;

endpackage

`default_nettype wire

//--- hdl/burst_channel.sv
`timescale 1ns/1ns
`default_nettype none

module burst_channel
  import axi_pkg::*;
#(
  parameter type payload_t = addr_phase_t
) (
  input  wire                ACLK,
  input  wire                ARESETn,
  input  wire payload_t      payload,
  input  wire                load,
  input  wire                ready,
  input  wire                beat_done,
  output logic               valid,
  output payload_t           addr_out,
  output logic               phase_done,
  output logic [ADDR_W-1:0]  beat_addr,
  output logic               last
);

  logic              valid_q;
  logic [LEN_W-1:0]  cnt_q;
  logic [ADDR_W-1:0] addr_q;
  payload_t          payload_q;

  assign valid      = valid_q;
  assign addr_out   = payload_q;
  assign phase_done = valid_q && ready;
  assign beat_addr  = addr_q;
  assign last       = (cnt_q == payload_q.len);

  //////////////////////////////////////////////////////////////////////
  // Address phase
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      valid_q <= 1'b0;
    end
    else if (load)
    begin
      valid_q <= 1'b1;
    end
    else if (phase_done)
    begin
      valid_q <= 1'b0;
    end
  end

  // Held stable while valid waits for ready
  always_ff @(posedge ACLK)
  begin
    if (load)
    begin
      payload_q <= payload;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Beat counting and address stepping
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      cnt_q  <= '0;
      addr_q <= '0;
    end
    else if (load)
    begin
      cnt_q  <= '0;
      addr_q <= payload.addr;
    end
    else if (beat_done)
    begin
      cnt_q <= cnt_q + LEN_W'(1);
      // FIXED keeps the start address on every beat
      if (payload_q.burst == BURST_INCR)
      begin
        addr_q <= addr_q + (ADDR_W'(1) << payload_q.size);
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/write_engine.sv
`timescale 1ns/1ns
`default_nettype none

module write_engine
  import axi_pkg::*;
#(
  parameter int DATA_WIDTH = DATA_W,
  parameter int ADDR_WIDTH = ADDR_W
) (
  input  wire                    ACLK,
  input  wire                    ARESETn,
  input  wire burst_cmd_t        cmd,
  input  wire                    start,
  output logic                   busy,
  // Write address channel
  output logic [ADDR_WIDTH-1:0]  AWADDR,
  output logic [LEN_W-1:0]       AWLEN,
  output logic [SIZE_W-1:0]      AWSIZE,
  output logic [1:0]             AWBURST,
  output logic                   AWVALID,
  input  wire                    AWREADY,
  // Write data channel
  output logic [DATA_WIDTH-1:0]  WDATA,
  output logic                   WLAST,
  output logic                   WVALID,
  input  wire                    WREADY
);

  addr_phase_t           aw_load;
  addr_phase_t           aw_phase;
  logic                  accept;
  logic                  aw_done;
  logic                  w_xfer;
  logic                  w_last;
  logic                  busy_q;
  logic                  wvalid_q;
  logic [DATA_WIDTH-1:0] wdata_q;

  assign accept = start && cmd.write && !busy_q;
  assign w_xfer = wvalid_q && WREADY;

  assign aw_load.addr  = cmd.addr;
  assign aw_load.len   = cmd.len;
  assign aw_load.size  = cmd.size;
  assign aw_load.burst = cmd.burst;

  burst_channel #(
    .payload_t (addr_phase_t)
  ) aw_chan_i (
    .ACLK       (ACLK),
    .ARESETn    (ARESETn),
    .payload    (aw_load),
    .load       (accept),
    .ready      (AWREADY),
    .beat_done  (w_xfer),
    .valid      (AWVALID),
    .addr_out   (aw_phase),
    .phase_done (aw_done),
    .beat_addr  (),
    .last       (w_last)
  );

  assign AWADDR  = aw_phase.addr;
  assign AWLEN   = aw_phase.len;
  assign AWSIZE  = aw_phase.size;
  assign AWBURST = aw_phase.burst;

  assign WDATA  = wdata_q;
  assign WLAST  = w_last;
  assign WVALID = wvalid_q;
  assign busy   = busy_q;

  //////////////////////////////////////////////////////////////////////
  // Data beats
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      busy_q   <= 1'b0;
      wvalid_q <= 1'b0;
    end
    else
    begin
      if (accept)
        busy_q <= 1'b1;
      else if (w_xfer && w_last)
        busy_q <= 1'b0;

      // First beat goes out the cycle after AW is taken
      if (aw_done)
        wvalid_q <= 1'b1;
      else if (w_xfer && w_last)
        wvalid_q <= 1'b0;
    end
  end

  // Beat i carries base + i
  always_ff @(posedge ACLK)
  begin
    if (accept)
      wdata_q <= cmd.data_base;
    else if (w_xfer)
      wdata_q <= wdata_q + DATA_WIDTH'(1);
  end

endmodule

`default_nettype wire

//--- hdl/read_engine.sv
`timescale 1ns/1ns
`default_nettype none

module read_engine
  import axi_pkg::*;
#(
  parameter int DATA_WIDTH = DATA_W,
  parameter int ADDR_WIDTH = ADDR_W
) (
  input  wire                    ACLK,
  input  wire                    ARESETn,
  input  wire burst_cmd_t        cmd,
  input  wire                    start,
  output logic                   busy,
  // Read address channel
  output logic [ADDR_WIDTH-1:0]  ARADDR,
  output logic [LEN_W-1:0]       ARLEN,
  output logic [SIZE_W-1:0]      ARSIZE,
  output logic [1:0]             ARBURST,
  output logic                   ARVALID,
  input  wire                    ARREADY,
  // Read data channel
  input  wire [DATA_WIDTH-1:0]   RDATA,
  input  wire                    RLAST,
  input  wire                    RVALID,
  output logic                   RREADY,
  // Beat report
  output rd_beat_t               rd_beat,
  output logic                   rd_valid
);

  addr_phase_t       ar_load;
  addr_phase_t       ar_phase;
  logic              accept;
  logic              ar_done;
  logic              r_xfer;
  logic [ADDR_W-1:0] cur_addr;
  logic              busy_q;
  logic              rready_q;
  logic              rd_valid_q;
  rd_beat_t          rd_beat_q;

  assign accept = start && !cmd.write && !busy_q;
  assign r_xfer = RVALID && rready_q;

  assign ar_load.addr  = cmd.addr;
  assign ar_load.len   = cmd.len;
  assign ar_load.size  = cmd.size;
  assign ar_load.burst = cmd.burst;

  burst_channel #(
    .payload_t (addr_phase_t)
  ) ar_chan_i (
    .ACLK       (ACLK),
    .ARESETn    (ARESETn),
    .payload    (ar_load),
    .load       (accept),
    .ready      (ARREADY),
    .beat_done  (r_xfer),
    .valid      (ARVALID),
    .addr_out   (ar_phase),
    .phase_done (ar_done),
    .beat_addr  (cur_addr),
    .last       ()
  );

  assign ARADDR  = ar_phase.addr;
  assign ARLEN   = ar_phase.len;
  assign ARSIZE  = ar_phase.size;
  assign ARBURST = ar_phase.burst;

  assign RREADY   = rready_q;
  assign rd_beat  = rd_beat_q;
  assign rd_valid = rd_valid_q;
  assign busy     = busy_q;

  // Burst ends on the slave's RLAST
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      busy_q     <= 1'b0;
      rready_q   <= 1'b0;
      rd_valid_q <= 1'b0;
    end
    else
    begin
      rd_valid_q <= r_xfer;
      if (accept)
        busy_q <= 1'b1;
      else if (r_xfer && RLAST)
        busy_q <= 1'b0;

      if (ar_done)
        rready_q <= 1'b1;
      else if (r_xfer && RLAST)
        rready_q <= 1'b0;
    end
  end

  always_ff @(posedge ACLK)
  begin
    if (r_xfer)
    begin
      rd_beat_q.addr <= cur_addr;
      rd_beat_q.data <= RDATA;
      rd_beat_q.last <= RLAST;
    end
  end

endmodule

`default_nettype wire

//--- hdl/axi_burst_master.sv
`timescale 1ns/1ns
`default_nettype none

module axi_burst_master
  import axi_pkg::*;
#(
  parameter int DATA_WIDTH = DATA_W,
  parameter int ADDR_WIDTH = ADDR_W
) (
  input  wire                    ACLK,
  input  wire                    ARESETn,
  // Command side
  input  wire burst_cmd_t        cmd,
  input  wire                    cmd_start,
  output logic                   busy,
  output rd_beat_t               rd_beat,
  output logic                   rd_valid,
  // Write address channel
  output logic [ADDR_WIDTH-1:0]  AWADDR,
  output logic [LEN_W-1:0]       AWLEN,
  output logic [SIZE_W-1:0]      AWSIZE,
  output logic [1:0]             AWBURST,
  output logic                   AWVALID,
  input  wire                    AWREADY,
  // Write data channel
  output logic [DATA_WIDTH-1:0]  WDATA,
  output logic                   WLAST,
  output logic                   WVALID,
  input  wire                    WREADY,
  // Read address channel
  output logic [ADDR_WIDTH-1:0]  ARADDR,
  output logic [LEN_W-1:0]       ARLEN,
  output logic [SIZE_W-1:0]      ARSIZE,
  output logic [1:0]             ARBURST,
  output logic                   ARVALID,
  input  wire                    ARREADY,
  // Read data channel
  input  wire [DATA_WIDTH-1:0]   RDATA,
  input  wire                    RLAST,
  input  wire                    RVALID,
  output logic                   RREADY
);

  logic start;
  logic wr_busy;
  logic rd_busy;

  // Struct fields are sized by the package defaults
  if (DATA_WIDTH != DATA_W || ADDR_WIDTH != ADDR_W)
  begin : g_width_check
    $error("axi_burst_master: DATA_WIDTH/ADDR_WIDTH must match axi_pkg");
  end

  // Strobes while busy are dropped
  assign start = cmd_start && !busy;
  assign busy  = wr_busy || rd_busy;

  write_engine #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) wr_eng_i (
    .ACLK    (ACLK),
    .ARESETn (ARESETn),
    .cmd     (cmd),
    .start   (start),
    .busy    (wr_busy),
    .AWADDR  (AWADDR),
    .AWLEN   (AWLEN),
    .AWSIZE  (AWSIZE),
    .AWBURST (AWBURST),
    .AWVALID (AWVALID),
    .AWREADY (AWREADY),
    .WDATA   (WDATA),
    .WLAST   (WLAST),
    .WVALID  (WVALID),
    .WREADY  (WREADY)
  );

  read_engine #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) rd_eng_i (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .cmd      (cmd),
    .start    (start),
    .busy     (rd_busy),
    .ARADDR   (ARADDR),
    .ARLEN    (ARLEN),
    .ARSIZE   (ARSIZE),
    .ARBURST  (ARBURST),
    .ARVALID  (ARVALID),
    .ARREADY  (ARREADY),
    .RDATA    (RDATA),
    .RLAST    (RLAST),
    .RVALID   (RVALID),
    .RREADY   (RREADY),
    .rd_beat  (rd_beat),
    .rd_valid (rd_valid)
  );

endmodule

`default_nettype wire

//--- verification/axi_protocol_chk.sv
`timescale 1ns/1ns
`default_nettype none

module axi_protocol_chk
  import axi_pkg::*;
(
  input wire              ACLK,
  input wire              ARESETn,
  input wire [ADDR_W-1:0] AWADDR,
  input wire [LEN_W-1:0]  AWLEN,
  input wire [SIZE_W-1:0] AWSIZE,
  input wire [1:0]        AWBURST,
  input wire              AWVALID,
  input wire              AWREADY,
  input wire [DATA_W-1:0] WDATA,
  input wire              WLAST,
  input wire              WVALID,
  input wire              WREADY,
  input wire [ADDR_W-1:0] ARADDR,
  input wire [LEN_W-1:0]  ARLEN,
  input wire [SIZE_W-1:0] ARSIZE,
  input wire [1:0]        ARBURST,
  input wire              ARVALID,
  input wire              ARREADY
);

  int               fail_count = 0;
  logic [LEN_W-1:0] aw_len_q;
  logic [LEN_W-1:0] w_cnt;

  // W beat index within the current burst
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      aw_len_q <= '0;
      w_cnt    <= '0;
    end
    else if (AWVALID && AWREADY)
    begin
      aw_len_q <= AWLEN;
      w_cnt    <= '0;
    end
    else if (WVALID && WREADY)
    begin
      w_cnt <= w_cnt + 1'b1;
    end
  end

  a_aw_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    AWVALID && !AWREADY |=> AWVALID && $stable({AWADDR, AWLEN, AWSIZE, AWBURST}))
  else
  begin
    $error("AWVALID dropped or AW payload changed before AWREADY");
    fail_count++;
  end

  a_w_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    WVALID && !WREADY |=> WVALID && $stable({WDATA, WLAST}))
  else
  begin
    $error("WVALID dropped or W payload changed before WREADY");
    fail_count++;
  end

  a_ar_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    ARVALID && !ARREADY |=> ARVALID && $stable({ARADDR, ARLEN, ARSIZE, ARBURST}))
  else
  begin
    $error("ARVALID dropped or AR payload changed before ARREADY");
    fail_count++;
  end

  a_wlast: assert property (@(posedge ACLK) disable iff (!ARESETn)
    WVALID |-> (WLAST == (w_cnt == aw_len_q)))
  else
  begin
    $error("WLAST does not match beat index against AWLEN");
    fail_count++;
  end

endmodule

`default_nettype wire

//--- verification/axi_slave_mem.sv
`timescale 1ns/1ns
`default_nettype none

module axi_slave_mem
  import axi_pkg::*;
(
  input  wire              ACLK,
  input  wire              ARESETn,
  input  wire [ADDR_W-1:0] AWADDR,
  input  wire [SIZE_W-1:0] AWSIZE,
  input  wire [1:0]        AWBURST,
  input  wire              AWVALID,
  output logic             AWREADY,
  input  wire [DATA_W-1:0] WDATA,
  input  wire              WVALID,
  output logic             WREADY,
  input  wire [ADDR_W-1:0] ARADDR,
  input  wire [LEN_W-1:0]  ARLEN,
  input  wire [SIZE_W-1:0] ARSIZE,
  input  wire [1:0]        ARBURST,
  input  wire              ARVALID,
  output logic             ARREADY,
  output logic [DATA_W-1:0] RDATA,
  output logic             RLAST,
  output logic             RVALID,
  input  wire              RREADY
);

  logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] w_addr;
  logic [SIZE_W-1:0] w_size;
  logic [1:0]        w_burst;
  logic [ADDR_W-1:0] r_addr;
  logic [SIZE_W-1:0] r_size;
  logic [1:0]        r_burst;
  logic [LEN_W-1:0]  r_len;
  logic [LEN_W-1:0]  r_cnt;
  logic              r_active;

  function automatic logic [ADDR_W-1:0] step_addr(logic [ADDR_W-1:0] a,
                                                   logic [SIZE_W-1:0] size,
                                                   logic [1:0] burst);
    if (burst == BURST_INCR)
      return a + (ADDR_W'(1) << size);
    return a;
  endfunction

  function automatic logic [DATA_W-1:0] read_word(logic [ADDR_W-1:0] a);
    return mem.exists(a) ? mem[a] : '0;
  endfunction

  always @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      AWREADY  <= 1'b0;
      WREADY   <= 1'b0;
      ARREADY  <= 1'b0;
      RVALID   <= 1'b0;
      RLAST    <= 1'b0;
      RDATA    <= '0;
      r_active = 1'b0;
    end
    else
    begin
      // Roughly one stall in four on every ready
      AWREADY <= ($urandom % 4) != 0;
      WREADY  <= ($urandom % 4) != 0;
      ARREADY <= ($urandom % 4) != 0;

      if (AWVALID && AWREADY)
      begin
        w_addr  = AWADDR;
        w_size  = AWSIZE;
        w_burst = AWBURST;
      end
      if (WVALID && WREADY)
      begin
        mem[w_addr] = WDATA;
        w_addr = step_addr(w_addr, w_size, w_burst);
      end

      if (ARVALID && ARREADY)
      begin
        r_addr   = ARADDR;
        r_len    = ARLEN;
        r_size   = ARSIZE;
        r_burst  = ARBURST;
        r_cnt    = '0;
        r_active = 1'b1;
      end
      if (RVALID && RREADY)
      begin
        r_addr = step_addr(r_addr, r_size, r_burst);
        r_cnt  = r_cnt + 1'b1;
        if (RLAST)
          r_active = 1'b0;
      end
      // A presented beat holds until taken
      if (!RVALID || RREADY)
      begin
        if (r_active && ($urandom % 4) != 0)
        begin
          RVALID <= 1'b1;
          RDATA  <= read_word(r_addr);
          RLAST  <= (r_cnt == r_len);
        end
        else
          RVALID <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/axi_scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module axi_scoreboard
  import axi_pkg::*;
(
  input  wire             ACLK,
  input  wire             ARESETn,
  input  wire burst_cmd_t cmd,
  input  wire             cmd_start,
  input  wire             busy,
  input  wire rd_beat_t   rd_beat,
  input  wire             rd_valid,
  output int              error_count,
  output int              pending
);

  logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
  rd_beat_t          exp_q [$];
  rd_beat_t          e;
  int                errors = 0;

  assign error_count = errors;
  assign pending     = exp_q.size();

  function automatic logic [ADDR_W-1:0] beat_addr(burst_cmd_t c, int i);
    if (c.burst == BURST_INCR)
      return c.addr + (ADDR_W'(i) << c.size);
    return c.addr;
  endfunction

  // Expected report for beat i of a read command
  function automatic rd_beat_t expect_beat(burst_cmd_t c, int i);
    rd_beat_t b;
    b.addr = beat_addr(c, i);
    b.data = shadow.exists(b.addr) ? shadow[b.addr] : '0;
    b.last = (i == int'(c.len));
    return b;
  endfunction

  task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act)
    begin
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  always @(posedge ACLK)
  begin
    if (ARESETn && rd_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Error at %0t: read beat reported with no read burst pending", $time);
        errors++;
      end
      else
      begin
        e = exp_q.pop_front();
        compare("rd_beat.addr", e.addr, rd_beat.addr);
        compare("rd_beat.data", e.data, rd_beat.data);
        compare("rd_beat.last", 32'(e.last), 32'(rd_beat.last));
      end
    end
    // Strobes while busy are dropped
    if (ARESETn && cmd_start && !busy)
    begin
      for (int i = 0; i <= int'(cmd.len); i++)
      begin
        if (cmd.write)
          shadow[beat_addr(cmd, i)] = cmd.data_base + DATA_W'(i);
        else
          exp_q.push_back(expect_beat(cmd, i));
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_axi_burst_master.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_burst_master
  import axi_pkg::*;
();

  localparam int N_RANDOM    = 40;
  localparam int N_BURSTS    = N_RANDOM + 8;
  localparam int CYCLE_LIMIT = N_BURSTS * 16 * 8 + 200;

  logic              ACLK = 1'b0;
  logic              ARESETn;
  burst_cmd_t        cmd;
  logic              cmd_start;
  logic              busy;
  rd_beat_t          rd_beat;
  logic              rd_valid;
  logic [ADDR_W-1:0] AWADDR;
  logic [LEN_W-1:0]  AWLEN;
  logic [SIZE_W-1:0] AWSIZE;
  logic [1:0]        AWBURST;
  logic              AWVALID;
  logic              AWREADY;
  logic [DATA_W-1:0] WDATA;
  logic              WLAST;
  logic              WVALID;
  logic              WREADY;
  logic [ADDR_W-1:0] ARADDR;
  logic [LEN_W-1:0]  ARLEN;
  logic [SIZE_W-1:0] ARSIZE;
  logic [1:0]        ARBURST;
  logic              ARVALID;
  logic              ARREADY;
  logic [DATA_W-1:0] RDATA;
  logic              RLAST;
  logic              RVALID;
  logic              RREADY;
  int                sb_errors;
  int                sb_pending;
  int                errors = 0;
  int                cycles = 0;

  always #4 ACLK = ~ACLK;

  axi_burst_master #(
    .DATA_WIDTH (DATA_W),
    .ADDR_WIDTH (ADDR_W)
  ) dut_i (.*);

  axi_slave_mem slave_i (.*);

  axi_scoreboard sb_i (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .cmd         (cmd),
    .cmd_start   (cmd_start),
    .busy        (busy),
    .rd_beat     (rd_beat),
    .rd_valid    (rd_valid),
    .error_count (sb_errors),
    .pending     (sb_pending)
  );

  bind axi_burst_master axi_protocol_chk chk_i (
    .ACLK    (ACLK),
    .ARESETn (ARESETn),
    .AWADDR  (AWADDR),
    .AWLEN   (AWLEN),
    .AWSIZE  (AWSIZE),
    .AWBURST (AWBURST),
    .AWVALID (AWVALID),
    .AWREADY (AWREADY),
    .WDATA   (WDATA),
    .WLAST   (WLAST),
    .WVALID  (WVALID),
    .WREADY  (WREADY),
    .ARADDR  (ARADDR),
    .ARLEN   (ARLEN),
    .ARSIZE  (ARSIZE),
    .ARBURST (ARBURST),
    .ARVALID (ARVALID),
    .ARREADY (ARREADY)
  );

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  function automatic burst_cmd_t make_cmd(logic [ADDR_W-1:0] addr, int len, int size,
                                          burst_e burst, logic write,
                                          logic [DATA_W-1:0] base);
    burst_cmd_t c;
    c.addr      = addr;
    c.len       = LEN_W'(len);
    c.size      = SIZE_W'(size);
    c.burst     = burst;
    c.write     = write;
    c.data_base = base;
    return c;
  endfunction

  task automatic expect_low(string name, logic v);
    if (v !== 1'b0)
    begin
      $display("FAIL %0t %s expected 0 got %b", $time, name, v);
      errors++;
    end
  endtask

  task automatic send_cmd(input burst_cmd_t c);
    @(posedge ACLK);
    cmd       <= c;
    cmd_start <= 1'b1;
    @(posedge ACLK);
    cmd_start <= 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge ACLK);
    while (busy)
      @(negedge ACLK);
  endtask

  task automatic run_burst(input burst_cmd_t c);
    send_cmd(c);
    wait_idle();
  endtask

  // Watchdog
  always @(posedge ACLK)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial
  begin
    burst_cmd_t c;
    int         total;
    void'($urandom(32'h778b));
    cmd       = '0;
    cmd_start = 1'b0;
    ARESETn   = 1'b0;
    repeat (10) @(posedge ACLK);
    ARESETn <= 1'b1;

    @(negedge ACLK);
    expect_low("AWVALID", AWVALID);
    expect_low("WVALID", WVALID);
    expect_low("ARVALID", ARVALID);
    expect_low("RREADY", RREADY);
    expect_low("rd_valid", rd_valid);
    expect_low("busy", busy);

    run_burst(make_cmd(32'd100, 3, 2, BURST_INCR, 1'b1, 32'h0000_a000));
    run_burst(make_cmd(32'd100, 3, 2, BURST_INCR, 1'b0, '0));
    run_burst(make_cmd(32'h200, 3, 2, BURST_FIXED, 1'b1, 32'h0000_b000));
    run_burst(make_cmd(32'h200, 3, 2, BURST_FIXED, 1'b0, '0));

    // Second strobe lands while the first write is still running
    send_cmd(make_cmd(32'h300, 7, 2, BURST_INCR, 1'b1, 32'h0000_c000));
    @(negedge ACLK);
    if (!busy)
    begin
      $display("Error at %0t: master idle when the overlapping strobe was sent", $time);
      errors++;
    end
    send_cmd(make_cmd(32'h800, 0, 2, BURST_INCR, 1'b1, 32'hdead_0000));
    wait_idle();
    repeat (4)
    begin
      @(negedge ACLK);
      if (busy)
      begin
        $display("Error at %0t: burst started from a strobe sent while busy", $time);
        errors++;
      end
    end
    run_burst(make_cmd(32'h800, 0, 2, BURST_INCR, 1'b0, '0));
    run_burst(make_cmd(32'h300, 7, 2, BURST_INCR, 1'b0, '0));

    for (int n = 0; n < N_RANDOM; n++)
    begin
      c.addr      = 32'h1000 + ($urandom % 64);
      c.len       = LEN_W'($urandom % 16);
      c.size      = SIZE_W'($urandom % 3);
      c.burst     = ($urandom % 2) ? BURST_INCR : BURST_FIXED;
      c.write     = $urandom % 2;
      c.data_base = $urandom;
      run_burst(c);
    end

    repeat (2) @(posedge ACLK);
    if (sb_pending != 0)
    begin
      $display("Error: %0d expected read beats were never reported", sb_pending);
      errors++;
    end
    total = errors + sb_errors + dut_i.chk_i.fail_count;
    $display("Errors: testbench %0d, scoreboard %0d, assertions %0d",
             errors, sb_errors, dut_i.chk_i.fail_count);
    if (total == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hdl/axi_pkg.sv
hdl/burst_channel.sv
hdl/write_engine.sv
hdl/read_engine.sv
hdl/axi_burst_master.sv
verification/axi_protocol_chk.sv
verification/axi_slave_mem.sv
verification/axi_scoreboard.sv
verification/tb_axi_burst_master.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then scan the log for the verdict
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -f sources.f \
  --top-module tb_axi_burst_master -o sim_tb \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0
